/* design/ccd_ctl_pkg.sv */
package ccd_ctl_pkg;

    // Host command bytes
    localparam logic [7:0] CMD_WRITE = 8'h02;
    localparam logic [7:0] CMD_READ  = 8'h03;

    // Register map
    localparam logic [7:0] ADDR_OP_COUNT  = 8'h03;
    localparam logic [7:0] ADDR_WIDTH_LO  = 8'h10;
    localparam logic [7:0] ADDR_WIDTH_HI  = 8'h11;
    localparam logic [7:0] ADDR_HEIGHT_LO = 8'h12;
    localparam logic [7:0] ADDR_HEIGHT_HI = 8'h13;
    localparam logic [7:0] ADDR_VPHASES   = 8'h14;
    localparam logic [7:0] ADDR_HPHASES   = 8'h15;
    localparam logic [7:0] ADDR_EXPOSE    = 8'h20; // Base of 0x20..0x23
    localparam logic [7:0] ADDR_ADC_LO    = 8'h40;
    localparam logic [7:0] ADDR_ADC_HI    = 8'h41;

    localparam logic [7:0] UNMAPPED_READ = 8'hAB;

    // One byte from the host link
    typedef struct packed {
        logic       sel;    // Frame active
        logic       strobe; // One-cycle byte valid
        logic [7:0] data;
    } ctl_byte_t;

    // Decoded register access
    typedef struct packed {
        logic       strobe;
        logic       is_write;
        logic [7:0] addr;
        logic [7:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic       strobe;
        logic [7:0] data;
    } rd_resp_t;

    // Low two address bits of the exposure commands
    typedef enum logic [1:0] {
        EXP_IDLE     = 2'd0,
        EXP_EXPOSE   = 2'd1,
        EXP_COMPLETE = 2'd2,
        EXP_READOUT  = 2'd3
    } exposure_mode_t;

    // Geometry and mode levels for the CCD timing generator
    typedef struct packed {
        logic [15:0] width;
        logic [15:0] height;
        logic [3:0]  vphases;
        logic [2:0]  hphases;
        logic        start_exposure;
        logic        complete_exposure;
        logic        start_read;
    } ccd_cfg_t;

endpackage

/* design/ccd_ctl_top.sv */
`timescale 1ns/1ns

module ccd_ctl_top import ccd_ctl_pkg::*; #(
    parameter int ADC_BITS = 12
) (
    input  logic                clk,
    input  logic                rst_n,
    input  ctl_byte_t           ctl_in,
    input  logic [ADC_BITS-1:0] adc,
    input  logic                store_sample,
    output ccd_cfg_t            ccd_cfg,
    output rd_resp_t            rd_resp
);

    reg_req_t   req;
    logic       op_start;
    logic [7:0] op_count;

    // Byte stream to register requests
    frame_decode frame_decode_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctl_in   (ctl_in),
        .req      (req),
        .op_start (op_start)
    );

    reg_execute reg_execute_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .op_start (op_start),
        .cfg      (ccd_cfg),
        .op_count (op_count)
    );

    // ADC capture and read data
    read_result #(
        .ADC_BITS (ADC_BITS)
    ) read_result_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .cfg          (ccd_cfg),
        .op_count     (op_count),
        .adc          (adc),
        .store_sample (store_sample),
        .rd_resp      (rd_resp)
    );

endmodule

/* design/frame_decode.sv */
`timescale 1ns/1ns

module frame_decode import ccd_ctl_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  ctl_byte_t ctl_in,
    output reg_req_t  req,
    output logic      op_start
);

    // Position of the next byte within the frame
    localparam logic [1:0] IDX_CMD  = 2'd0;
    localparam logic [1:0] IDX_ADDR = 2'd1;
    localparam logic [1:0] IDX_DATA = 2'd2;
    localparam logic [1:0] IDX_DONE = 2'd3;

    logic [1:0] byte_idx;
    logic [7:0] cmd;
    logic       byte_valid;

    assign byte_valid = ctl_in.sel && ctl_in.strobe;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            byte_idx   <= IDX_CMD;
            op_start   <= 1'b0;
            req.strobe <= 1'b0;
        end else begin
            op_start   <= 1'b0;
            req.strobe <= 1'b0;

            if (!ctl_in.sel) begin
                byte_idx <= IDX_CMD; // Frame over or abandoned
            end else if (byte_valid) begin
                case (byte_idx)
                    IDX_CMD: begin
                        cmd      <= ctl_in.data;
                        op_start <= 1'b1;
                        byte_idx <= IDX_ADDR;
                    end

                    IDX_ADDR: begin
                        req.addr <= ctl_in.data;
                        if (cmd == CMD_READ) begin
                            req.strobe   <= 1'b1;
                            req.is_write <= 1'b0;
                            byte_idx     <= IDX_DONE;
                        end else if (cmd == CMD_WRITE) begin
                            byte_idx <= IDX_DATA;
                        end else begin
                            byte_idx <= IDX_DONE; // Unknown command swallows the rest
                        end
                    end

                    IDX_DATA: begin
                        req.strobe   <= 1'b1;
                        req.is_write <= 1'b1;
                        req.wdata    <= ctl_in.data;
                        byte_idx     <= IDX_DONE;
                    end

                    default: begin
                        byte_idx <= IDX_DONE; // Trailing bytes ignored until sel drops
                    end
                endcase
            end
        end
    end

endmodule

/* design/read_result.sv */
`timescale 1ns/1ns

module read_result import ccd_ctl_pkg::*; #(
    parameter int ADC_BITS = 12
) (
    input  logic                clk,
    input  logic                rst_n,
    input  reg_req_t            req,
    input  ccd_cfg_t            cfg,
    input  logic [7:0]          op_count,
    input  logic [ADC_BITS-1:0] adc,
    input  logic                store_sample,
    output rd_resp_t            rd_resp
);

    logic                store_q;
    logic [ADC_BITS-1:0] adc_q;
    logic [15:0]         adc_ext;
    logic [7:0]          rd_data;
    logic                rd_en;

    assign rd_en   = req.strobe && !req.is_write;
    assign adc_ext = 16'(adc_q); // High bits zero

    // ADC capture on rising edge of store_sample
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            store_q <= 1'b0;
            adc_q   <= '0;
        end else begin
            store_q <= store_sample;
            if (store_sample && !store_q) begin
                adc_q <= adc;
            end
        end
    end

    always_comb begin
        case (req.addr)
            ADDR_OP_COUNT:  rd_data = op_count;
            ADDR_WIDTH_LO:  rd_data = cfg.width[7:0];
            ADDR_WIDTH_HI:  rd_data = cfg.width[15:8];
            ADDR_HEIGHT_LO: rd_data = cfg.height[7:0];
            ADDR_HEIGHT_HI: rd_data = cfg.height[15:8];
            ADDR_VPHASES:   rd_data = {4'h0, cfg.vphases};
            ADDR_HPHASES:   rd_data = {5'h0, cfg.hphases};
            ADDR_ADC_LO:    rd_data = adc_ext[7:0];
            ADDR_ADC_HI:    rd_data = adc_ext[15:8];
            default:        rd_data = UNMAPPED_READ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_resp.strobe <= 1'b0;
        end else begin
            rd_resp.strobe <= rd_en;
            if (rd_en) begin
                rd_resp.data <= rd_data;
            end
        end
    end

endmodule

/* design/reg_execute.sv */
`timescale 1ns/1ns

module reg_execute import ccd_ctl_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_req_t req,
    input  logic     op_start,
    output ccd_cfg_t cfg,
    output logic [7:0] op_count
);

    logic [15:0]    width_q;
    logic [15:0]    height_q;
    logic [3:0]     vphases_q;
    logic [2:0]     hphases_q;
    exposure_mode_t mode_q;
    logic [2:0]     levels; // start_exposure, complete_exposure, start_read
    logic           wr_en;
    logic           is_expose;

    assign wr_en     = req.strobe && req.is_write;
    assign is_expose = (req.addr[7:2] == ADDR_EXPOSE[7:2]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            width_q   <= '0;
            height_q  <= '0;
            vphases_q <= '0;
            hphases_q <= '0;
            mode_q    <= EXP_IDLE;
            op_count  <= '0;
        end else begin
            if (op_start) begin
                op_count <= op_count + 8'd1; // Wraps at 256
            end

            if (wr_en) begin
                case (req.addr)
                    ADDR_WIDTH_LO:  width_q[7:0]   <= req.wdata;
                    ADDR_WIDTH_HI:  width_q[15:8]  <= req.wdata;
                    ADDR_HEIGHT_LO: height_q[7:0]  <= req.wdata;
                    ADDR_HEIGHT_HI: height_q[15:8] <= req.wdata;
                    ADDR_VPHASES:   vphases_q      <= req.wdata[3:0];
                    ADDR_HPHASES:   hphases_q      <= req.wdata[2:0];
                    default: begin
                        if (is_expose) begin
                            mode_q <= exposure_mode_t'(req.addr[1:0]);
                        end
                    end
                endcase
            end
        end
    end

    // Mode to CCD control levels
    always_comb begin
        case (mode_q)
            EXP_IDLE:     levels = 3'b000;
            EXP_EXPOSE:   levels = 3'b110;
            EXP_COMPLETE: levels = 3'b010;
            EXP_READOUT:  levels = 3'b001;
            default:      levels = 3'b000;
        endcase
    end

    always_comb begin
        cfg.width             = width_q;
        cfg.height            = height_q;
        cfg.vphases           = vphases_q;
        cfg.hphases           = hphases_q;
        cfg.start_exposure    = levels[2];
        cfg.complete_exposure = levels[1];
        cfg.start_read        = levels[0];
    end

endmodule

/* sim/tb_ccd_ctl.sv */
`timescale 1ns/1ns

module tb_ccd_ctl
    import ccd_ctl_pkg::*;
();

    localparam int          ADC_BITS   = 12;
    localparam logic [31:0] SEED       = 32'hf5a95581;
    localparam int          NUM_WRITES = 150;
    localparam int          NUM_ADC    = 20;

    // Frames in the run with each ADC sample counted as one frame
    localparam int NUM_FRAMES   = 2 * NUM_WRITES + 3 * NUM_ADC + 64;
    localparam int FRAME_CYCLES = 16; // Longest frame with trailing bytes and idle gap
    localparam int CYCLE_LIMIT  = NUM_FRAMES * FRAME_CYCLES + 100;

    localparam logic [1:0] MODE_SEQ [7] = '{2'd1, 2'd2, 2'd3, 2'd0, 2'd2, 2'd1, 2'd3};
    localparam logic [7:0] BAD_WR_ADDRS [6] = '{8'h03, 8'h16, 8'h24, 8'h40, 8'h41, 8'hFF};
    localparam logic [7:0] BAD_RD_ADDRS [7] = '{8'h00, 8'h04, 8'h16, 8'h20, 8'h23, 8'h42, 8'hFF};

    logic                clk = 1'b0;
    logic                rst_n;
    ctl_byte_t           ctl_in;
    logic [ADC_BITS-1:0] adc;
    logic                store_sample;
    ccd_cfg_t            ccd_cfg;
    rd_resp_t            rd_resp;

    // Reference model state
    ccd_cfg_t            model_cfg = '0;
    logic [7:0]          model_count = '0;
    logic [ADC_BITS-1:0] model_adc = '0;

    // Expectations set with the completing byte and delayed by two cycles
    ccd_cfg_t exp_cfg    = '0;
    ccd_cfg_t exp_cfg_d1 = '0;
    ccd_cfg_t exp_cfg_d2 = '0;
    rd_resp_t exp_rd     = '0;
    rd_resp_t exp_rd_d1  = '0;
    rd_resp_t exp_rd_d2  = '0;

    string test_name = "reset";
    int    cycle_count = 0;

    always #4 clk = ~clk;

    ccd_ctl_top #(
        .ADC_BITS (ADC_BITS)
    ) dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctl_in       (ctl_in),
        .adc          (adc),
        .store_sample (store_sample),
        .ccd_cfg      (ccd_cfg),
        .rd_resp      (rd_resp)
    );

    always @(posedge clk) begin
        exp_cfg_d1 <= exp_cfg;
        exp_cfg_d2 <= exp_cfg_d1;
        exp_rd_d1  <= exp_rd;
        exp_rd_d2  <= exp_rd_d1;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles, last test %s",
                     CYCLE_LIMIT, test_name);
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

    task automatic report_mismatch(input string what, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("Error: test %s, %s expected %h, actual %h", test_name, what, expected, actual);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    // Sampled at the falling edge after the rising-edge drives settle
    cfg_matches: assert property (@(negedge clk) disable iff (!rst_n)
        ccd_cfg == exp_cfg_d2)
        else report_mismatch("ccd_cfg", exp_cfg_d2, ccd_cfg);

    one_strobe_per_read: assert property (@(negedge clk) disable iff (!rst_n)
        rd_resp.strobe == exp_rd_d2.strobe)
        else report_mismatch("rd_resp.strobe", exp_rd_d2.strobe, rd_resp.strobe);

    read_data_matches: assert property (@(negedge clk) disable iff (!rst_n)
        rd_resp.strobe |-> rd_resp.data == exp_rd_d2.data)
        else report_mismatch("rd_resp.data", exp_rd_d2.data, rd_resp.data);

    function automatic logic [7:0] expected_read(input logic [7:0] addr);
        logic [15:0] adc_wide;
        adc_wide = 16'(model_adc);
        case (addr)
            ADDR_OP_COUNT:  return model_count;
            ADDR_WIDTH_LO:  return model_cfg.width[7:0];
            ADDR_WIDTH_HI:  return model_cfg.width[15:8];
            ADDR_HEIGHT_LO: return model_cfg.height[7:0];
            ADDR_HEIGHT_HI: return model_cfg.height[15:8];
            ADDR_VPHASES:   return 8'(model_cfg.vphases);
            ADDR_HPHASES:   return 8'(model_cfg.hphases);
            ADDR_ADC_LO:    return adc_wide[7:0];
            ADDR_ADC_HI:    return adc_wide[15:8];
            default:        return UNMAPPED_READ;
        endcase
    endfunction

    task automatic set_levels(input logic start_exp, input logic complete_exp,
                              input logic start_rd);
        model_cfg.start_exposure    = start_exp;
        model_cfg.complete_exposure = complete_exp;
        model_cfg.start_read        = start_rd;
    endtask

    task automatic apply_write(input logic [7:0] addr, input logic [7:0] data);
        case (addr)
            ADDR_WIDTH_LO:      model_cfg.width[7:0]   = data;
            ADDR_WIDTH_HI:      model_cfg.width[15:8]  = data;
            ADDR_HEIGHT_LO:     model_cfg.height[7:0]  = data;
            ADDR_HEIGHT_HI:     model_cfg.height[15:8] = data;
            ADDR_VPHASES:       model_cfg.vphases      = data[3:0];
            ADDR_HPHASES:       model_cfg.hphases      = data[2:0];
            ADDR_EXPOSE:        set_levels(1'b0, 1'b0, 1'b0);
            ADDR_EXPOSE + 8'd1: set_levels(1'b1, 1'b1, 1'b0);
            ADDR_EXPOSE + 8'd2: set_levels(1'b0, 1'b1, 1'b0);
            ADDR_EXPOSE + 8'd3: set_levels(1'b0, 1'b0, 1'b1);
            default: ;
        endcase
    endtask

    task automatic put_byte(input logic [7:0] data);
        @(posedge clk);
        ctl_in <= '{sel: 1'b1, strobe: 1'b1, data: data};
    endtask

    // One cycle with sel held and no byte
    task automatic gap();
        @(posedge clk);
        ctl_in.strobe <= 1'b0;
        exp_rd.strobe <= 1'b0;
    endtask

    task automatic end_frame();
        @(posedge clk);
        ctl_in        <= '0;
        exp_rd.strobe <= 1'b0;
        repeat ($urandom_range(0, 2)) @(posedge clk);
    endtask

    task automatic trailing_bytes(input logic [7:0] first, input int count);
        for (int i = 0; i < count; i++) begin
            put_byte((i == 0) ? first : 8'($urandom));
            gap();
        end
    endtask

    task automatic write_frame(input logic [7:0] addr, input logic [7:0] data, input int extra);
        put_byte(CMD_WRITE);
        model_count++;
        gap();
        put_byte(addr);
        gap();
        put_byte(data);
        apply_write(addr, data);
        exp_cfg <= model_cfg;
        gap();
        trailing_bytes(CMD_WRITE, extra);
        end_frame();
    endtask

    task automatic read_frame(input logic [7:0] addr, input int extra);
        put_byte(CMD_READ);
        model_count++; // Count includes the read frame itself
        gap();
        put_byte(addr);
        exp_rd <= '{strobe: 1'b1, data: expected_read(addr)};
        gap();
        trailing_bytes(CMD_READ, extra);
        end_frame();
    endtask

    task automatic unknown_frame(input logic [7:0] cmd);
        put_byte(cmd);
        model_count++;
        gap();
        trailing_bytes(ADDR_WIDTH_LO, 2); // Address and data that a write would apply
        end_frame();
    endtask

    // Drops sel after num_bytes bytes before the frame completes
    task automatic abandon_frame(input logic [7:0] cmd, input int num_bytes);
        put_byte(cmd);
        model_count++;
        gap();
        trailing_bytes(ADDR_WIDTH_HI, num_bytes - 1);
        end_frame();
    endtask

    task automatic sample_adc(input logic [ADC_BITS-1:0] value);
        @(posedge clk);
        adc <= ADC_BITS'($urandom); // Not captured while store is low
        @(posedge clk);
        adc          <= value;
        store_sample <= 1'b1;
        model_adc     = value;
        repeat ($urandom_range(1, 4)) begin
            @(posedge clk);
            adc <= ADC_BITS'($urandom); // No new capture while store is held high
        end
        @(posedge clk);
        store_sample <= 1'b0;
        @(posedge clk);
    endtask

    initial begin
        logic [7:0] addr;
        logic [7:0] cmd;

        void'($urandom(SEED));
        rst_n        = 1'b0;
        ctl_in       = '0;
        adc          = '0;
        store_sample = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        test_name = "count_after_reset";
        read_frame(ADDR_OP_COUNT, 0);

        test_name = "geometry_writes";
        repeat (NUM_WRITES) begin
            addr = ADDR_WIDTH_LO + 8'($urandom_range(0, 5));
            write_frame(addr, 8'($urandom), 0);
            read_frame(addr, 0);
        end
        for (int a = ADDR_WIDTH_LO; a <= ADDR_HPHASES; a++) begin
            read_frame(8'(a), 0);
        end

        test_name = "exposure_modes";
        foreach (MODE_SEQ[i]) begin
            write_frame(ADDR_EXPOSE + 8'(MODE_SEQ[i]), 8'($urandom), 0);
        end
        repeat (8) write_frame(ADDR_EXPOSE + 8'($urandom_range(0, 3)), 8'($urandom), 0);

        test_name = "unmapped_writes";
        foreach (BAD_WR_ADDRS[i]) write_frame(BAD_WR_ADDRS[i], 8'($urandom), 0);

        test_name = "unmapped_reads";
        foreach (BAD_RD_ADDRS[i]) read_frame(BAD_RD_ADDRS[i], 0);

        test_name = "adc_capture";
        repeat (NUM_ADC) begin
            sample_adc(ADC_BITS'($urandom));
            read_frame(ADDR_ADC_LO, 0);
            read_frame(ADDR_ADC_HI, 0);
        end

        test_name = "unknown_commands";
        repeat (8) begin
            do begin
                cmd = 8'($urandom);
            end while (cmd == CMD_WRITE || cmd == CMD_READ);
            unknown_frame(cmd);
        end

        test_name = "trailing_bytes";
        write_frame(ADDR_HEIGHT_LO, 8'($urandom), 2);
        read_frame(ADDR_HEIGHT_LO, 2);
        read_frame(ADDR_OP_COUNT, 1);

        test_name = "abandoned_frames";
        abandon_frame(CMD_WRITE, 2);
        read_frame(ADDR_WIDTH_HI, 0);
        abandon_frame(CMD_READ, 1);
        abandon_frame(CMD_WRITE, 1);
        write_frame(ADDR_VPHASES, 8'($urandom), 0);
        read_frame(ADDR_VPHASES, 0);

        test_name = "op_count_wrap";
        read_frame(ADDR_OP_COUNT, 0);

        repeat (4) @(posedge clk); // Last response through the pipeline
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* src.f */
design/ccd_ctl_pkg.sv
design/frame_decode.sv
design/reg_execute.sv
design/read_result.sv
design/ccd_ctl_top.sv
sim/tb_ccd_ctl.sv
